// File: aes_round_pipe.f
+incdir+include
source/aes_op_pkg.sv
source/aes_state_pkg.sv
source/gf_inv_8.sv
source/sbox_canright.sv
source/sub_shift_stage.sv
source/mix_columns_stage.sv
source/add_round_key_stage.sv
source/aes_round_pipe.sv
verification/aes_round_pipe_sva.sv
verification/aes_round_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the AES round pipeline testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --assert --timescale 1ns/1ps \
    --top-module aes_round_pipe_tb -Mdir obj_dir -f aes_round_pipe.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vaes_round_pipe_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
else
    exit 1
fi

// File: include/aes_round_ref.svh
// Reference model of one AES round for the testbench
// The including scope must import aes_op_pkg and aes_state_pkg
// Decrypt rounds expect keys already passed through InvMixColumns
// Slow search-based inverse so keep it out of tight loops
`ifndef AES_ROUND_REF_SVH
`define AES_ROUND_REF_SVH

// GF(2^8) multiply modulo the AES polynomial
function automatic logic [7:0] ref_gf_mul(input logic [7:0] x, input logic [7:0] y);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = 8'h00;
    sh  = x;
    for (int i = 0; i < 8; i++) begin
        if (y[i]) begin
            acc ^= sh;
        end
        sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
    end
    return acc;
endfunction

// Inverse by search with zero kept at zero
function automatic logic [7:0] ref_gf_inv(input logic [7:0] x);
    logic [7:0] inv;
    inv = 8'h00;
    for (int i = 1; i < 256; i++) begin
        if (ref_gf_mul(x, 8'(i)) == 8'h01) begin
            inv = 8'(i);
        end
    end
    return inv;
endfunction

function automatic logic [7:0] ref_rotl(input logic [7:0] x, input int n);
    return (x << n) | (x >> (8 - n));
endfunction

// Inverse then affine
function automatic logic [7:0] ref_sbox(input logic [7:0] x);
    logic [7:0] b;
    b = ref_gf_inv(x);
    return b ^ ref_rotl(b, 1) ^ ref_rotl(b, 2) ^ ref_rotl(b, 3) ^ ref_rotl(b, 4) ^ 8'h63;
endfunction

// Inverse affine then inverse
function automatic logic [7:0] ref_inv_sbox(input logic [7:0] x);
    return ref_gf_inv(ref_rotl(x, 1) ^ ref_rotl(x, 3) ^ ref_rotl(x, 6) ^ 8'h05);
endfunction

// Substitution and row shift in one pass
function automatic aes_state_t ref_sub_shift(input aes_state_t s, input logic decrypt);
    aes_state_t res;
    int         src;
    for (int i = 0; i < 16; i++) begin
        src = decrypt ? ((i / 4 + 4 - i % 4) % 4) * 4 + i % 4 : ((i / 4 + i % 4) % 4) * 4 + i % 4;
        res[127 - 8*i -: 8] = decrypt ? ref_inv_sbox(s[127 - 8*src -: 8])
                                      : ref_sbox(s[127 - 8*src -: 8]);
    end
    return res;
endfunction

// Column mix with full multiplies
function automatic aes_state_t ref_mix_columns(input aes_state_t s, input logic decrypt);
    aes_state_t res;
    logic [7:0] coef [4];
    logic [7:0] acc;
    if (decrypt) begin
        coef = '{8'd14, 8'd11, 8'd13, 8'd9};
    end else begin
        coef = '{8'd2, 8'd3, 8'd1, 8'd1};
    end
    for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) begin
            acc = 8'h00;
            for (int k = 0; k < 4; k++) begin
                acc ^= ref_gf_mul(coef[(k + 4 - r) % 4], s[127 - 8*(4*c + k) -: 8]);
            end
            res[127 - 8*(4*c + r) -: 8] = acc;
        end
    end
    return res;
endfunction

// Full round as the pipeline computes it
function automatic aes_state_t ref_round(input aes_state_t s, input aes_key_t key,
                                         input round_op_e op);
    aes_state_t t;
    logic       decrypt;
    logic       last;
    // Both inverse-cipher opcodes and both last-round opcodes
    decrypt = (op == op_dec) || (op == op_dec_last);
    last    = (op == op_enc_last) || (op == op_dec_last);
    t = ref_sub_shift(s, decrypt);
    if (!last) begin
        t = ref_mix_columns(t, decrypt);
    end
    return t ^ key;
endfunction

`endif

// File: verification/aes_round_pipe_tb.sv
// Directed testbench for the three-stage AES round pipeline
// Scoreboard expects outputs strictly in input order
// Decrypt tests supply keys already run through InvMixColumns
`include "aes_round_macros.svh"

module aes_round_pipe_tb import aes_op_pkg::*, aes_state_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    `include "aes_round_ref.svh"

    // Cycle budget per test including drains
    localparam int test_cycles = 16 + 9 + 64 + 32 + 88;
    localparam int max_cycles  = test_cycles + 50;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    round_op_e  in_op;
    aes_state_t in_state;
    aes_key_t   in_key;
    logic       out_valid;
    round_op_e  out_op;
    aes_state_t out_state;

    aes_state_t exp_state_q [$];
    round_op_e  exp_op_q [$];
    aes_state_t got_q [$];
    logic [`AES_PIPE_DEPTH-1:0] valid_hist;
    int error_count;
    int check_count;
    int test_count;
    int cycle_count;

    aes_round_pipe aes_round_pipe_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_state  (in_state),
        .in_key    (in_key),
        .out_valid (out_valid),
        .out_op    (out_op),
        .out_state (out_state)
    );

    bind aes_round_pipe aes_round_pipe_sva aes_round_pipe_sva_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .out_valid (out_valid),
        .out_op    (out_op)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard and watchdog
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
            error_count++;
        end
    endtask

    // Outputs sampled on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("out_valid", out_valid, valid_hist[`AES_PIPE_DEPTH-1]);
            if (out_valid) begin
                assert (exp_state_q.size() != 0) else begin
                    $display("Output appeared with no item outstanding");
                    error_count++;
                end
                if (exp_state_q.size() != 0) begin
                    check_value("out_state", out_state, exp_state_q.pop_front());
                    check_value("out_op", out_op, exp_op_q.pop_front());
                    got_q.push_back(out_state);
                end
            end
        end
        // in_valid as seen one depth ago
        valid_hist = {valid_hist[`AES_PIPE_DEPTH-2:0], in_valid};
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > max_cycles) begin
            $display("Timeout: run went past %0d cycles", max_cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Drive helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_item(input round_op_e op, input aes_state_t state,
                             input aes_key_t key, input aes_state_t expected);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_op    = op;
        in_state = state;
        in_key   = key;
        exp_state_q.push_back(expected);
        exp_op_q.push_back(op);
    endtask

    task automatic send_bubble();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_state = '0;
        in_key   = '0;
    endtask

    // Wait until every outstanding item has come out
    task automatic drain_pipe();
        send_bubble();
        while (exp_state_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        $display("Test %s %s, %0d errors", name,
                 (error_count == errors_before) ? "passed" : "failed",
                 error_count - errors_before);
    endtask

    function automatic aes_state_t random_state();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int errors_before;
        errors_before = error_count;
        rst_n = 1'b0;
        // Ten rising edges with reset applied
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            check_value("out_valid", out_valid, 1'b0);
        end
        rst_n = 1'b1;
        // Idle cycles after release
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 1'b0);
        end
        report_test("reset state", errors_before);
    endtask

    // FIPS-197 appendix B, round 1
    task automatic test_known_round();
        int errors_before;
        errors_before = error_count;
        send_item(op_enc, 128'h193de3bea0f4e22b9ac68d2ae9f84808,
                  128'ha0fafe1788542cb123a339392a6c7605,
                  128'ha49c7ff2689f352b6b5bea43026a5049);
        drain_pipe();
        report_test("known round", errors_before);
    endtask

    task automatic test_sbox_last_rounds();
        int errors_before;
        aes_state_t src [`AES_STATE_BYTES];
        errors_before = error_count;
        got_q.delete();
        // Sixteen states cover all byte values
        for (int k = 0; k < `AES_STATE_BYTES; k++) begin
            for (int b = 0; b < 16; b++) begin
                src[k][127 - 8*b -: 8] = 8'(16*k + b);
            end
        end
        for (int k = 0; k < `AES_STATE_BYTES; k++) begin
            send_item(op_enc_last, src[k], '0, ref_round(src[k], '0, op_enc_last));
        end
        for (int k = 0; k < `AES_STATE_BYTES; k++) begin
            send_item(op_dec_last, src[k], '0, ref_round(src[k], '0, op_dec_last));
        end
        drain_pipe();
        check_value("result count", got_q.size(), 2 * `AES_STATE_BYTES);
        // Inverse substitution of the forward results
        for (int k = 0; k < `AES_STATE_BYTES; k++) begin
            send_item(op_dec_last, got_q[k], '0, src[k]);
        end
        drain_pipe();
        report_test("sbox last rounds", errors_before);
    endtask

    task automatic test_decrypt_inverts();
        int errors_before;
        aes_state_t states [8];
        aes_key_t   keys [8];
        aes_state_t t;
        errors_before = error_count;
        got_q.delete();
        for (int i = 0; i < 8; i++) begin
            states[i] = random_state();
            keys[i]   = random_state();
            send_item(op_enc, states[i], keys[i], ref_round(states[i], keys[i], op_enc));
        end
        drain_pipe();
        check_value("result count", got_q.size(), 8);
        // Undo the key and the column mix
        // The dec round then yields InvMixColumns of the start state
        for (int i = 0; i < 8; i++) begin
            t = ref_mix_columns(got_q[i] ^ keys[i], 1'b1);
            send_item(op_dec, t, '0, ref_mix_columns(states[i], 1'b1));
        end
        drain_pipe();
        for (int i = 0; i < 8; i++) begin
            check_value("recovered state", ref_mix_columns(got_q[8 + i], 1'b0), states[i]);
        end
        report_test("decrypt inverts", errors_before);
    endtask

    task automatic test_back_to_back();
        int errors_before;
        round_op_e  op;
        aes_state_t state;
        aes_key_t   key;
        errors_before = error_count;
        for (int i = 0; i < 40; i++) begin
            if ($urandom_range(3, 0) == 0) begin
                send_bubble();
            end
            op    = round_op_e'($urandom_range(3, 0));
            state = random_state();
            key   = random_state();
            send_item(op, state, key, ref_round(state, key, op));
        end
        drain_pipe();
        report_test("back to back", errors_before);
    endtask

    initial begin
        void'($urandom(32'hd67f));
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        cycle_count = 0;
        valid_hist  = '0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_op    = op_enc;
        in_state = '0;
        in_key   = '0;
        test_reset_state();
        test_known_round();
        test_sbox_last_rounds();
        test_decrypt_inverts();
        test_back_to_back();
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verification/aes_round_pipe_sva.sv
// Concurrent checks on the ports of the AES round pipeline
// Attached to aes_round_pipe by a bind in the testbench
// Latency checks assume no back-pressure and a fixed depth
`include "aes_round_macros.svh"

module aes_round_pipe_sva import aes_op_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      in_valid,
    input round_op_e in_op,
    input logic      out_valid,
    input round_op_e out_op
);

    timeunit 1ns;
    timeprecision 1ps;

    // Output register cleared by every reset edge
    a_idle_in_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high while reset is applied");

    // Valid and bubbles both travel the full depth
    a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, `AES_PIPE_DEPTH))
        else $error("out_valid does not follow in_valid by the pipeline depth");

    // Opcode rides along with its item
    a_op_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_op == $past(in_op, `AES_PIPE_DEPTH))
        else $error("out_op does not match in_op from the pipeline depth earlier");

endmodule

// File: source/aes_round_pipe.sv
// One AES round as a three-stage pipeline
// Latency is three cycles with one item accepted per cycle
// No back-pressure so the consumer must take every out_valid
// Decrypt follows the equivalent inverse cipher
module aes_round_pipe import aes_op_pkg::*, aes_state_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  round_op_e  in_op,
    input  aes_state_t in_state,
    input  aes_key_t   in_key,
    output logic       out_valid,
    output round_op_e  out_op,
    output aes_state_t out_state
);

    stage_item_t s0_item;
    stage_item_t s1_item;
    stage_item_t s2_item;

    // Input bundle
    assign s0_item = '{valid: in_valid, op: in_op, state: in_state, key: in_key};

    // SubBytes and ShiftRows
    sub_shift_stage sub_shift_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_item  (s0_item),
        .out_item (s1_item)
    );

    // MixColumns unless last round
    mix_columns_stage mix_columns_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_item  (s1_item),
        .out_item (s2_item)
    );

    // AddRoundKey
    add_round_key_stage add_round_key_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_item   (s2_item),
        .out_valid (out_valid),
        .out_op    (out_op),
        .out_state (out_state)
    );

endmodule

// File: source/add_round_key_stage.sv
// Final pipeline stage with AddRoundKey
// The key is used here and is not passed on
module add_round_key_stage import aes_op_pkg::*, aes_state_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  stage_item_t in_item,
    output logic        out_valid,
    output round_op_e   out_op,
    output aes_state_t  out_state
);

    aes_state_t keyed;

    // Same XOR for both directions
    assign keyed = in_item.state ^ in_item.key;

    // Output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_op    <= op_enc;
            out_state <= '0;
        end else begin
            out_valid <= in_item.valid;
            out_op    <= in_item.op;
            out_state <= keyed;
        end
    end

endmodule

// File: source/mix_columns_stage.sv
// Second pipeline stage with MixColumns or InvMixColumns
// Last-round opcodes pass the state through unchanged
// Multiplies are built from xtime chains only
`include "aes_round_macros.svh"

module mix_columns_stage import aes_op_pkg::*, aes_state_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  stage_item_t in_item,
    output stage_item_t out_item
);

    localparam int num_cols = `AES_STATE_BYTES / 4;

    // Multiply by 2 modulo the AES polynomial
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // One column, row 0 in the top byte
    function automatic logic [31:0] mix_column(input logic [31:0] col, input logic decrypt);
        logic [7:0]  x1 [4];
        logic [7:0]  x2 [4];
        logic [7:0]  x4 [4];
        logic [7:0]  x8 [4];
        logic [7:0]  k0 [4];
        logic [7:0]  k1 [4];
        logic [7:0]  k2 [4];
        logic [7:0]  k3 [4];
        logic [31:0] res;
        for (int k = 0; k < 4; k++) begin
            x1[k] = col[31 - 8*k -: 8];
            x2[k] = xtime(x1[k]);
            x4[k] = xtime(x2[k]);
            x8[k] = xtime(x4[k]);
            if (decrypt) begin
                // 14 11 13 9
                k0[k] = x8[k] ^ x4[k] ^ x2[k];
                k1[k] = x8[k] ^ x2[k] ^ x1[k];
                k2[k] = x8[k] ^ x4[k] ^ x1[k];
                k3[k] = x8[k] ^ x1[k];
            end else begin
                // 2 3 1 1
                k0[k] = x2[k];
                k1[k] = x2[k] ^ x1[k];
                k2[k] = x1[k];
                k3[k] = x1[k];
            end
        end
        // Coefficients rotate one place per row
        for (int r = 0; r < 4; r++) begin
            res[31 - 8*r -: 8] = k0[r] ^ k1[(r + 1) % 4] ^ k2[(r + 2) % 4] ^ k3[(r + 3) % 4];
        end
        return res;
    endfunction

    aes_state_t mixed;

    for (genvar c = 0; c < num_cols; c++) begin : g_col
        assign mixed[127 - 32*c -: 32] =
            mix_column(in_item.state[127 - 32*c -: 32], op_is_decrypt(in_item.op));
    end

    // Stage register with last-round bypass
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_item <= '0;
        end else begin
            out_item.valid <= in_item.valid;
            out_item.op    <= in_item.op;
            out_item.state <= op_is_last(in_item.op) ? in_item.state : mixed;
            out_item.key   <= in_item.key;
        end
    end

endmodule

// File: source/sub_shift_stage.sv
// First pipeline stage with SubBytes and ShiftRows
// Decrypt opcodes use the inverse S-box and the right row shift
// Sixteen S-boxes in parallel make this the longest combinational path
`include "aes_round_macros.svh"

module sub_shift_stage import aes_op_pkg::*, aes_state_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  stage_item_t in_item,
    output stage_item_t out_item
);

    logic       encrypt;
    logic [7:0] sub_bytes [`AES_STATE_BYTES];
    aes_state_t enc_shift;
    aes_state_t dec_shift;

    assign encrypt = !op_is_decrypt(in_item.op);

    // One S-box per byte
    // Row shift is pure wiring so it is folded into the same loop
    for (genvar i = 0; i < `AES_STATE_BYTES; i++) begin : g_byte
        localparam int row     = i % 4;
        localparam int col     = i / 4;
        // Source byte for the left shift
        localparam int src_enc = ((col + row) % 4) * 4 + row;
        // Source byte for the right shift
        localparam int src_dec = ((col + 4 - row) % 4) * 4 + row;

        sbox_canright sbox_canright_inst (
            .a       (in_item.state[127 - 8*i -: 8]),
            .encrypt (encrypt),
            .q       (sub_bytes[i])
        );

        assign enc_shift[127 - 8*i -: 8] = sub_bytes[src_enc];
        assign dec_shift[127 - 8*i -: 8] = sub_bytes[src_dec];
    end

    // Stage register
    // op and key ride along for the later stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_item <= '0;
        end else begin
            out_item.valid <= in_item.valid;
            out_item.op    <= in_item.op;
            out_item.state <= encrypt ? enc_shift : dec_shift;
            out_item.key   <= in_item.key;
        end
    end

endmodule

// File: source/sbox_canright.sv
// Combinational AES S-box after Canright's compact design
// encrypt high gives the forward S-box and low gives the inverse S-box
// Affine steps are folded into the basis changes around gf_inv_8
// Purely combinational so timing closes only with a register after it
module sbox_canright (
    input  logic [7:0] a,
    input  logic       encrypt,
    output logic [7:0] q
);

    logic [7:0] enc_basis;
    logic [7:0] dec_basis;
    logic [7:0] inv_in;
    logic [7:0] inv_out;
    logic [7:0] enc_out;
    logic [7:0] dec_out;
    logic r1, r2, r3, r4, r5, r6, r7, r8, r9;
    logic t1, t2, t3, t4, t5, t6, t7, t8, t9, t10;

    ////////////////////////////////////////////////////////////////////////////
    // Into the tower basis
    ////////////////////////////////////////////////////////////////////////////

    // Shared terms
    assign r1 = a[7] ^ a[5];
    assign r2 = a[7] ~^ a[4];
    assign r3 = a[6] ^ a[0];
    assign r4 = a[5] ~^ r3;
    assign r5 = a[4] ^ r4;
    assign r6 = a[3] ^ a[0];
    assign r7 = a[2] ^ r1;
    assign r8 = a[1] ^ r3;
    assign r9 = a[3] ^ r8;

    // Plain basis change for the forward path
    assign enc_basis[7] = r7 ~^ r8;
    assign enc_basis[6] = r5;
    assign enc_basis[5] = a[1] ^ r4;
    assign enc_basis[4] = r1 ~^ r3;
    assign enc_basis[3] = a[1] ^ r2 ^ r6;
    assign enc_basis[2] = ~a[0];
    assign enc_basis[1] = r4;
    assign enc_basis[0] = a[2] ~^ r9;

    // Inverse affine merged with the basis change
    assign dec_basis[7] = r2;
    assign dec_basis[6] = a[4] ^ r8;
    assign dec_basis[5] = a[6] ^ a[4];
    assign dec_basis[4] = r9;
    assign dec_basis[3] = a[6] ~^ r2;
    assign dec_basis[2] = r7;
    assign dec_basis[1] = a[4] ^ r6;
    assign dec_basis[0] = a[1] ^ r5;

    // Inverting select, the complements above compensate
    assign inv_in = ~(encrypt ? enc_basis : dec_basis);

    gf_inv_8 gf_inv_8_inst (
        .a (inv_in),
        .q (inv_out)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Back to the polynomial basis
    ////////////////////////////////////////////////////////////////////////////

    assign t1  = inv_out[7] ^ inv_out[3];
    assign t2  = inv_out[6] ^ inv_out[4];
    assign t3  = inv_out[6] ^ inv_out[0];
    assign t4  = inv_out[5] ~^ inv_out[3];
    assign t5  = inv_out[5] ~^ t1;
    assign t6  = inv_out[5] ~^ inv_out[1];
    assign t7  = inv_out[4] ~^ t6;
    assign t8  = inv_out[2] ^ t4;
    assign t9  = inv_out[1] ^ t2;
    assign t10 = t3 ^ t5;

    // Forward affine merged with the basis change
    assign enc_out[7] = t4;
    assign enc_out[6] = t1;
    assign enc_out[5] = t3;
    assign enc_out[4] = t5;
    assign enc_out[3] = t2 ^ t5;
    assign enc_out[2] = t3 ^ t8;
    assign enc_out[1] = t7;
    assign enc_out[0] = t9;

    // Plain basis change for the inverse path
    assign dec_out[7] = inv_out[4] ~^ inv_out[1];
    assign dec_out[6] = inv_out[1] ^ t10;
    assign dec_out[5] = inv_out[2] ^ t10;
    assign dec_out[4] = inv_out[6] ~^ inv_out[1];
    assign dec_out[3] = t8 ^ t9;
    assign dec_out[2] = inv_out[7] ~^ t7;
    assign dec_out[1] = t6;
    assign dec_out[0] = ~inv_out[2];

    assign q = ~(encrypt ? enc_out : dec_out);

endmodule

// File: source/gf_inv_8.sv
// Combinational GF(2^8) inverse in the Canright tower basis
// Input and output are in the GF(2^8)/GF(2^4)/GF(2^2) normal basis
// Zero maps to zero
module gf_inv_8 (
    input  logic [7:0] a,
    output logic [7:0] q
);

    // GF(2^2) multiply in normal basis [w^2, w]
    function automatic logic [1:0] gf2_mul(input logic [1:0] x, input logic [1:0] y);
        logic e;
        // Shared cross term
        e = (x[1] ^ x[0]) & (y[1] ^ y[0]);
        return {(x[1] & y[1]) ^ e, (x[0] & y[0]) ^ e};
    endfunction

    // Scale by n = w^2
    function automatic logic [1:0] gf2_scl_n(input logic [1:0] x);
        return {x[0], x[1] ^ x[0]};
    endfunction

    // Scale by n^2 = w
    function automatic logic [1:0] gf2_scl_n2(input logic [1:0] x);
        return {x[1] ^ x[0], x[1]};
    endfunction

    // GF(2^4) multiply over GF(2^2)
    function automatic logic [3:0] gf4_mul(input logic [3:0] x, input logic [3:0] y);
        logic [1:0] ph;
        logic [1:0] pl;
        logic [1:0] ps;
        ph = gf2_mul(x[3:2], y[3:2]);
        pl = gf2_mul(x[1:0], y[1:0]);
        // Sum product scaled by n feeds both halves
        ps = gf2_scl_n(gf2_mul(x[3:2] ^ x[1:0], y[3:2] ^ y[1:0]));
        return {ph ^ ps, pl ^ ps};
    endfunction

    // Square then scale by nu
    function automatic logic [3:0] gf4_sq_scl(input logic [3:0] x);
        logic [1:0] sum;
        sum = x[3:2] ^ x[1:0];
        // Squaring in a normal basis is a bit swap
        return {sum[0], sum[1], gf2_scl_n2({x[0], x[1]})};
    endfunction

    // GF(2^4) inverse over GF(2^2)
    function automatic logic [3:0] gf4_inv(input logic [3:0] x);
        logic [1:0] sum;
        logic [1:0] c;
        logic [1:0] d;
        sum = x[3:2] ^ x[1:0];
        c   = gf2_mul(x[3:2], x[1:0]) ^ gf2_scl_n({sum[0], sum[1]});
        // GF(2^2) inverse equals the square
        d   = {c[0], c[1]};
        return {gf2_mul(d, x[1:0]), gf2_mul(d, x[3:2])};
    endfunction

    logic [3:0] hi;
    logic [3:0] lo;
    logic [3:0] norm;
    logic [3:0] norm_inv;

    assign hi = a[7:4];
    assign lo = a[3:0];

    // Norm into GF(2^4)
    assign norm     = gf4_mul(hi, lo) ^ gf4_sq_scl(hi ^ lo);
    assign norm_inv = gf4_inv(norm);

    // Halves swap roles on the way out
    assign q = {gf4_mul(norm_inv, lo), gf4_mul(norm_inv, hi)};

endmodule

// File: source/aes_state_pkg.sv
// State, key and stage item types for the AES round datapath
// Byte 0 sits in bits 127:120 and bytes run column by column as in FIPS-197
// Keys carry no parity or expansion data
package aes_state_pkg;

    import aes_op_pkg::*;

    // One 128-bit AES state
    typedef logic [127:0] aes_state_t;

    // Round key in the same byte layout as the state
    typedef logic [127:0] aes_key_t;

    // Item handed from one stage to the next
    // valid low marks a bubble that still moves every cycle
    typedef struct packed {
        logic       valid;
        round_op_e  op;
        aes_state_t state;
        aes_key_t   key;
    } stage_item_t;

endpackage

// File: source/aes_op_pkg.sv
// Round opcodes for the AES round datapath
// Bit 1 selects the inverse cipher and bit 0 marks a last round
// Decrypt opcodes expect round keys already run through InvMixColumns
package aes_op_pkg;

    // Two-bit round opcode
    typedef enum logic [1:0] {
        op_enc      = 2'b00,
        op_enc_last = 2'b01,
        op_dec      = 2'b10,
        op_dec_last = 2'b11
    } round_op_e;

    // True for both inverse-cipher opcodes
    function automatic logic op_is_decrypt(input round_op_e op);
        return (op == op_dec) || (op == op_dec_last);
    endfunction

    // True when the column mix is skipped
    function automatic logic op_is_last(input round_op_e op);
        return (op == op_enc_last) || (op == op_dec_last);
    endfunction

endpackage

// File: include/aes_round_macros.svh
// Build-wide constants for the AES round datapath
// Pipeline depth is fixed by the three registered stages
// Changing the byte count alone does not resize the datapath
`ifndef AES_ROUND_MACROS_SVH
`define AES_ROUND_MACROS_SVH

// Bytes in one 128-bit AES state
`define AES_STATE_BYTES 16

// Cycles from in_valid to out_valid
`define AES_PIPE_DEPTH 3

`endif
